//--- compile.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/decode_pkg.sv
rtl/imm_gen.sv
rtl/op_decode.sv
rtl/fault_squash.sv
rtl/pc_cir_ctrl.sv
rtl/decode_top.sv
verif/tb_clk_gen.sv
verif/tb_decode_top.sv

//--- rtl/decode_defs.svh
// Decode stage widths, reset vector and sequential PC step
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Data and address width, one word
`define DEC_XLEN 32

// Register index width, enough for x0..x31
`define DEC_REGADDR_W 5

// First fetch address after reset
`define DEC_RESET_VECTOR 32'h0000_0100

// Every instruction is 32 bits wide, so the PC and the link value step by 4
`define DEC_PC_STEP 32'd4

`endif

//--- rtl/decode_pkg.sv
// Decode control encodings, the control bundle and the fetch and jump structs
`default_nettype none
`include "decode_defs.svh"

package decode_pkg;

	typedef enum logic [3:0] {
		ALUOP_ADD, ALUOP_SUB, ALUOP_SLL, ALUOP_LT, ALUOP_LTU,
		ALUOP_XOR, ALUOP_SRL, ALUOP_SRA, ALUOP_OR, ALUOP_AND
	} aluop_e;

	typedef enum logic [3:0] {
		MEMOP_NONE, MEMOP_LB, MEMOP_LH, MEMOP_LW, MEMOP_LBU,
		MEMOP_LHU, MEMOP_SB, MEMOP_SH, MEMOP_SW
	} memop_e;

	// Branch taken test applied to the ALU result in execute
	typedef enum logic [1:0] {
		BCOND_NEVER, BCOND_ZERO, BCOND_NZERO, BCOND_ALWAYS
	} bcond_e;

	typedef enum logic {SRCA_RS1, SRCA_PC} alusrc_a_e;
	typedef enum logic {SRCB_RS2, SRCB_IMM} alusrc_b_e;

	typedef enum logic [1:0] {
		EXCEPT_NONE, EXCEPT_INSTR_FAULT, EXCEPT_INSTR_ILLEGAL
	} except_e;

	// Everything execute needs to run one instruction
	typedef struct packed {
		logic [`DEC_REGADDR_W-1:0] rs1;
		logic [`DEC_REGADDR_W-1:0] rs2;
		logic [`DEC_REGADDR_W-1:0] rd;
		logic [`DEC_XLEN-1:0]      imm;
		alusrc_a_e                 alusrc_a;
		alusrc_b_e                 alusrc_b;
		aluop_e                    aluop;
		memop_e                    memop;
		bcond_e                    branchcond;
		logic [`DEC_XLEN-1:0]      addr_offs;
		logic                      addr_is_regoffs;
		except_e                   except;
	} dec_ctrl_t;

	// Current instruction register as presented by fetch
	typedef struct packed {
		rv_isa_pkg::rv_instr_t instr;
		logic                  valid;
		logic                  err;
	} fetch_cir_t;

	typedef struct packed {
		logic                 now;
		logic [`DEC_XLEN-1:0] target;
		logic                 not_except;
	} jump_req_t;

endpackage

`default_nettype wire

//--- rtl/decode_top.sv
// Decode stage top level chaining the decode sections beside the PC and CIR controller
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module decode_top (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire decode_pkg::fetch_cir_t cir_i,
	input  wire decode_pkg::jump_req_t  jump_i,
	input  wire                         x_stall_i,
	output decode_pkg::dec_ctrl_t       ctrl_o,
	output logic [`DEC_XLEN-1:0]        pc_o,
	output logic                        cir_use_o,
	output logic                        cir_lock_o,
	output logic                        starved_o
);

	logic [`DEC_XLEN-1:0]  imm_i;
	logic [`DEC_XLEN-1:0]  imm_s;
	logic [`DEC_XLEN-1:0]  imm_b;
	logic [`DEC_XLEN-1:0]  imm_u;
	logic [`DEC_XLEN-1:0]  imm_j;
	logic [`DEC_XLEN-1:0]  addr_offs;
	decode_pkg::dec_ctrl_t ctrl_raw;
	logic                  illegal;
	logic                  lock_prev;

	imm_gen u_imm_gen (
		.instr_i     (cir_i.instr),
		.imm_i_o     (imm_i),
		.imm_s_o     (imm_s),
		.imm_b_o     (imm_b),
		.imm_u_o     (imm_u),
		.imm_j_o     (imm_j),
		.addr_offs_o (addr_offs)
	);

	op_decode u_op_decode (
		.instr_i     (cir_i.instr),
		.imm_i_i     (imm_i),
		.imm_s_i     (imm_s),
		.imm_b_i     (imm_b),
		.imm_u_i     (imm_u),
		.imm_j_i     (imm_j),
		.addr_offs_i (addr_offs),
		.ctrl_o      (ctrl_raw),
		.illegal_o   (illegal)
	);

	fault_squash u_fault_squash (
		.ctrl_i      (ctrl_raw),
		.illegal_i   (illegal),
		.starved_i   (starved_o),
		.fetch_err_i (cir_i.err),
		.lock_prev_i (lock_prev),
		.ctrl_o      (ctrl_o)
	);

	pc_cir_ctrl u_pc_cir_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.cir_valid_i (cir_i.valid),
		.x_stall_i   (x_stall_i),
		.jump_i      (jump_i),
		.pc_o        (pc_o),
		.cir_use_o   (cir_use_o),
		.cir_lock_o  (cir_lock_o),
		.lock_prev_o (lock_prev),
		.starved_o   (starved_o)
	);

endmodule

`default_nettype wire

//--- rtl/fault_squash.sv
// Fault squash stage that cancels side effects and attaches the exception code
`timescale 1ns/1ps
`default_nettype none

module fault_squash (
	input  wire decode_pkg::dec_ctrl_t ctrl_i,
	input  wire                        illegal_i,
	input  wire                        starved_i,
	input  wire                        fetch_err_i,
	input  wire                        lock_prev_i,
	output decode_pkg::dec_ctrl_t      ctrl_o
);

	logic fault;

	// A bus error only counts once the word it came with is actually valid
	assign fault = fetch_err_i && !starved_i;

	always_comb begin
		ctrl_o = ctrl_i;

		if (fault || illegal_i || starved_i) begin
			ctrl_o.rs1        = '0;
			ctrl_o.rs2        = '0;
			ctrl_o.rd         = '0;
			ctrl_o.memop      = decode_pkg::MEMOP_NONE;
			ctrl_o.branchcond = decode_pkg::BCOND_NEVER;
			// Fetch fault wins, and garbage in a starved CIR is never reported
			if (fault)
				ctrl_o.except = decode_pkg::EXCEPT_INSTR_FAULT;
			else if (illegal_i && !starved_i)
				ctrl_o.except = decode_pkg::EXCEPT_INSTR_ILLEGAL;
			else
				ctrl_o.except = decode_pkg::EXCEPT_NONE;
		end

		// The jump was already issued before the lock, so it must not fire again
		if (lock_prev_i)
			ctrl_o.branchcond = decode_pkg::BCOND_NEVER;

		assert (ctrl_o.except == decode_pkg::EXCEPT_NONE ||
			ctrl_o.memop == decode_pkg::MEMOP_NONE)
			else $error("fault_squash: excepting instruction keeps a memory access");
	end

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
// Immediate generator for the five RV32I formats and the address offset select
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module imm_gen (
	input  wire rv_isa_pkg::rv_instr_t instr_i,
	output logic [`DEC_XLEN-1:0]      imm_i_o,
	output logic [`DEC_XLEN-1:0]      imm_s_o,
	output logic [`DEC_XLEN-1:0]      imm_b_o,
	output logic [`DEC_XLEN-1:0]      imm_u_o,
	output logic [`DEC_XLEN-1:0]      imm_j_o,
	output logic [`DEC_XLEN-1:0]      addr_offs_o
);

	logic [`DEC_XLEN-1:0] ir;

	assign ir = instr_i;

	// Bit 31 is the sign in every format
	assign imm_i_o = {{21{ir[31]}}, ir[30:20]};
	assign imm_s_o = {{21{ir[31]}}, ir[30:25], ir[11:7]};
	assign imm_b_o = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
	assign imm_u_o = {ir[31:12], 12'h000};
	assign imm_j_o = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

	// Offset added to the PC or rs1 to form a jump, branch or memory address
	always_comb begin
		case (instr_i.opcode)
			rv_isa_pkg::OP_JAL:    addr_offs_o = imm_j_o;
			rv_isa_pkg::OP_BRANCH: addr_offs_o = imm_b_o;
			rv_isa_pkg::OP_STORE:  addr_offs_o = imm_s_o;
			rv_isa_pkg::OP_JALR,
			rv_isa_pkg::OP_LOAD:   addr_offs_o = imm_i_o;
			default:               addr_offs_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/op_decode.sv
// Opcode decoder producing the raw execute control bundle and the illegal flag
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module op_decode (
	input  wire rv_isa_pkg::rv_instr_t instr_i,
	input  wire [`DEC_XLEN-1:0]        imm_i_i,
	input  wire [`DEC_XLEN-1:0]        imm_s_i,
	input  wire [`DEC_XLEN-1:0]        imm_b_i,
	input  wire [`DEC_XLEN-1:0]        imm_u_i,
	input  wire [`DEC_XLEN-1:0]        imm_j_i,
	input  wire [`DEC_XLEN-1:0]        addr_offs_i,
	output decode_pkg::dec_ctrl_t      ctrl_o,
	output logic                       illegal_o
);

	logic f7_base;
	logic f7_alt;
	logic is_jump;

	assign f7_base = instr_i.funct7 == rv_isa_pkg::F7_BASE;
	assign f7_alt  = instr_i.funct7 == rv_isa_pkg::F7_ALT;
	assign is_jump = instr_i.opcode == rv_isa_pkg::OP_JAL ||
		instr_i.opcode == rv_isa_pkg::OP_JALR;

	always_comb begin
		ctrl_o.rs1             = instr_i.rs1;
		ctrl_o.rs2             = instr_i.rs2;
		ctrl_o.rd              = instr_i.rd;
		ctrl_o.imm             = imm_i_i;
		ctrl_o.alusrc_a        = decode_pkg::SRCA_RS1;
		ctrl_o.alusrc_b        = decode_pkg::SRCB_RS2;
		ctrl_o.aluop           = decode_pkg::ALUOP_ADD;
		ctrl_o.memop           = decode_pkg::MEMOP_NONE;
		ctrl_o.branchcond      = decode_pkg::BCOND_NEVER;
		ctrl_o.addr_offs       = addr_offs_i;
		ctrl_o.addr_is_regoffs = 1'b0;
		ctrl_o.except          = decode_pkg::EXCEPT_NONE;
		illegal_o              = 1'b0;

		case (instr_i.opcode)
			rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG: begin
				case (instr_i.funct3)
					rv_isa_pkg::F3_ADD:  ctrl_o.aluop = decode_pkg::ALUOP_ADD;
					rv_isa_pkg::F3_SLL:  ctrl_o.aluop = decode_pkg::ALUOP_SLL;
					rv_isa_pkg::F3_SLT:  ctrl_o.aluop = decode_pkg::ALUOP_LT;
					rv_isa_pkg::F3_SLTU: ctrl_o.aluop = decode_pkg::ALUOP_LTU;
					rv_isa_pkg::F3_XOR:  ctrl_o.aluop = decode_pkg::ALUOP_XOR;
					rv_isa_pkg::F3_SRL:  ctrl_o.aluop = f7_alt ?
						decode_pkg::ALUOP_SRA : decode_pkg::ALUOP_SRL;
					rv_isa_pkg::F3_OR:   ctrl_o.aluop = decode_pkg::ALUOP_OR;
					default:             ctrl_o.aluop = decode_pkg::ALUOP_AND;
				endcase
				if (instr_i.opcode == rv_isa_pkg::OP_IMM) begin
					// Only the shifts carry funct7 in the immediate form
					ctrl_o.alusrc_b = decode_pkg::SRCB_IMM;
					ctrl_o.rs2      = '0;
					illegal_o = (instr_i.funct3 == rv_isa_pkg::F3_SLL && !f7_base) ||
						(instr_i.funct3 == rv_isa_pkg::F3_SRL && !f7_base && !f7_alt);
				end else begin
					if (instr_i.funct3 == rv_isa_pkg::F3_ADD && f7_alt)
						ctrl_o.aluop = decode_pkg::ALUOP_SUB;
					illegal_o = !(f7_base || (f7_alt &&
						(instr_i.funct3 == rv_isa_pkg::F3_ADD ||
						instr_i.funct3 == rv_isa_pkg::F3_SRL)));
				end
			end
			rv_isa_pkg::OP_LOAD: begin
				ctrl_o.addr_is_regoffs = 1'b1;
				ctrl_o.rs2             = '0;
				case (instr_i.funct3)
					3'b000:  ctrl_o.memop = decode_pkg::MEMOP_LB;
					3'b001:  ctrl_o.memop = decode_pkg::MEMOP_LH;
					3'b010:  ctrl_o.memop = decode_pkg::MEMOP_LW;
					3'b100:  ctrl_o.memop = decode_pkg::MEMOP_LBU;
					3'b101:  ctrl_o.memop = decode_pkg::MEMOP_LHU;
					default: illegal_o    = 1'b1;
				endcase
			end
			rv_isa_pkg::OP_STORE: begin
				ctrl_o.addr_is_regoffs = 1'b1;
				ctrl_o.rd              = '0;
				case (instr_i.funct3)
					3'b000:  ctrl_o.memop = decode_pkg::MEMOP_SB;
					3'b001:  ctrl_o.memop = decode_pkg::MEMOP_SH;
					3'b010:  ctrl_o.memop = decode_pkg::MEMOP_SW;
					default: illegal_o    = 1'b1;
				endcase
			end
			rv_isa_pkg::OP_BRANCH: begin
				ctrl_o.rd = '0;
				case (instr_i.funct3[2:1])
					2'b00:   ctrl_o.aluop = decode_pkg::ALUOP_SUB;
					2'b10:   ctrl_o.aluop = decode_pkg::ALUOP_LT;
					2'b11:   ctrl_o.aluop = decode_pkg::ALUOP_LTU;
					default: illegal_o    = 1'b1;
				endcase
				// BEQ, BGE and BGEU take the branch on a zero result, the others on nonzero
				ctrl_o.branchcond = (instr_i.funct3[2] == instr_i.funct3[0]) ?
					decode_pkg::BCOND_ZERO : decode_pkg::BCOND_NZERO;
			end
			rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
				// Execute computes the link value PC + 4 while fetch takes the jump
				ctrl_o.branchcond = decode_pkg::BCOND_ALWAYS;
				ctrl_o.alusrc_a   = decode_pkg::SRCA_PC;
				ctrl_o.alusrc_b   = decode_pkg::SRCB_IMM;
				ctrl_o.imm        = `DEC_PC_STEP;
				ctrl_o.rs2        = '0;
				if (instr_i.opcode == rv_isa_pkg::OP_JAL) begin
					ctrl_o.rs1 = '0;
				end else begin
					ctrl_o.addr_is_regoffs = 1'b1;
					illegal_o              = instr_i.funct3 != 3'b000;
				end
			end
			rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
				ctrl_o.imm      = imm_u_i;
				ctrl_o.alusrc_b = decode_pkg::SRCB_IMM;
				ctrl_o.rs1      = '0;
				ctrl_o.rs2      = '0;
				if (instr_i.opcode == rv_isa_pkg::OP_AUIPC)
					ctrl_o.alusrc_a = decode_pkg::SRCA_PC;
			end
			rv_isa_pkg::OP_FENCE: begin
				// No caches or reordering here, so FENCE retires as a no-op
				ctrl_o.rd = '0;
				illegal_o = instr_i.funct3 != 3'b000;
			end
			default: begin
				illegal_o = 1'b1;
			end
		endcase

		assert (ctrl_o.branchcond != decode_pkg::BCOND_ALWAYS || is_jump)
			else $error("op_decode: unconditional jump on non-jump opcode");
		// The offset from imm_gen has to match the format of the control transfer or store
		assert ((instr_i.opcode != rv_isa_pkg::OP_JAL || addr_offs_i == imm_j_i) &&
			(instr_i.opcode != rv_isa_pkg::OP_BRANCH || addr_offs_i == imm_b_i) &&
			(instr_i.opcode != rv_isa_pkg::OP_STORE || addr_offs_i == imm_s_i))
			else $error("op_decode: address offset format mismatch");
	end

endmodule

`default_nettype wire

//--- rtl/pc_cir_ctrl.sv
// Decode PC register, CIR lock, starved and consume strobes
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module pc_cir_ctrl (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        cir_valid_i,
	input  wire                        x_stall_i,
	input  wire decode_pkg::jump_req_t jump_i,
	output logic [`DEC_XLEN-1:0]       pc_o,
	output logic                       cir_use_o,
	output logic                       cir_lock_o,
	output logic                       lock_prev_o,
	output logic                       starved_o
);

	logic d_stall;
	logic jump_by_d;
	logic lock_set;
	logic lock_release;
	logic lock_prev;

	assign starved_o = !cir_valid_i;
	assign d_stall   = x_stall_i || starved_o;
	assign cir_use_o = !d_stall;

	// A jump issued by the instruction in decode while decode cannot retire it.
	// The CIR is held so fetch data cannot overwrite the link or recovery work
	assign jump_by_d    = jump_i.now && jump_i.not_except;
	assign lock_set     = jump_by_d && d_stall;
	assign lock_release = !d_stall;
	assign cir_lock_o   = (lock_prev && !lock_release) || lock_set;
	assign lock_prev_o  = lock_prev;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lock_prev <= 1'b0;
		else
			lock_prev <= cir_lock_o;
	end

	// ----------------------------------------
	// PC follows the instruction in the CIR
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_o <= `DEC_RESET_VECTOR;
		end else if ((jump_i.now && !lock_set) || (lock_prev && lock_release)) begin
			pc_o <= jump_i.target;
		end else if (!d_stall && !cir_lock_o) begin
			pc_o <= pc_o + `DEC_PC_STEP;
		end
	end

	a_no_use_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!(cir_use_o && x_stall_i))
		else $error("pc_cir_ctrl: CIR consumed during execute stall");

	a_lock_rise_stalled: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cir_lock_o) |-> (x_stall_i || starved_o))
		else $error("pc_cir_ctrl: CIR lock raised without a stall");

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
// RV32I instruction field view with opcode, funct3 and funct7 constants
`default_nettype none
`include "decode_defs.svh"

package rv_isa_pkg;

	typedef struct packed {
		logic [6:0]                funct7;
		logic [`DEC_REGADDR_W-1:0] rs2;
		logic [`DEC_REGADDR_W-1:0] rs1;
		logic [2:0]                funct3;
		logic [`DEC_REGADDR_W-1:0] rd;
		logic [6:0]                opcode;
	} rv_instr_t;

	// ----------------------------------------
	// Major opcodes, low two bits always 2'b11
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_FENCE  = 7'b0001111;

	// ----------------------------------------
	// ALU funct3, shared by OP_IMM and OP_REG
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SRL  = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// SUB and SRA are the alternate forms of ADD and SRL
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module tb_decode_top -Mdir obj_dir

./obj_dir/Vtb_decode_top | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
	exit 0
fi
exit 1

//--- verif/tb_clk_gen.sv
// Testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_PERIOD) clk_o = ~clk_o;
	end

	// Release lands on a falling edge, away from the rising edges
	initial begin
		rst_n_o = 1'b0;
		#(2 * HALF_PERIOD * RESET_CYCLES) rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- verif/tb_decode_top.sv
// Decode stage testbench with stimulus, LFSR, reference rules and checking assertions
`timescale 1ns/1ps
`default_nettype none
`include "decode_defs.svh"

module tb_decode_top;

	localparam int DRIVE_DLY  = 1;
	localparam int MAX_CYCLES = 400;

	logic                   clk;
	logic                   rst_n;
	decode_pkg::fetch_cir_t cir_i;
	decode_pkg::jump_req_t  jump_i;
	logic                   x_stall_i;
	decode_pkg::dec_ctrl_t  ctrl_o;
	logic [`DEC_XLEN-1:0]   pc_o;
	logic                   cir_use_o;
	logic                   cir_lock_o;
	logic                   starved_o;

	// Expected values are written just after a rising edge and stay stable until the next one
	decode_pkg::dec_ctrl_t exp_ctrl;
	logic [`DEC_XLEN-1:0]  exp_pc;
	logic [2:0]            exp_flags;
	logic                  chk_on;
	logic                  chk_offs;
	string                 test_name;
	int                    err_cnt;
	int                    cycles;
	logic [31:0]           lfsr;

	// Reference model of the PC and lock with the inputs of the cycle in progress
	logic [`DEC_XLEN-1:0]   m_pc;
	logic                   m_lock_prev;
	decode_pkg::fetch_cir_t prev_cir;
	decode_pkg::jump_req_t  prev_jump;
	logic                   prev_stall;

	tb_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	decode_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cir_i      (cir_i),
		.jump_i     (jump_i),
		.x_stall_i  (x_stall_i),
		.ctrl_o     (ctrl_o),
		.pc_o       (pc_o),
		.cir_use_o  (cir_use_o),
		.cir_lock_o (cir_lock_o),
		.starved_o  (starved_o)
	);

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic show_fail(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		err_cnt++;
		$display("FAIL %s %s expected %h actual %h", test_name, what, exp_v, act_v);
	endtask

	// ----------------------------------------
	// Reference decode of one CIR word
	task automatic expect_ctrl(input logic [31:0] w, input logic valid, input logic err);
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [2:0]  f3;
		logic        bad;
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'h000};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		f3 = w[14:12];
		bad = 1'b0;
		chk_offs = 1'b1;
		exp_ctrl = '0;
		exp_ctrl.rs1 = w[19:15];
		exp_ctrl.rs2 = w[24:20];
		exp_ctrl.rd = w[11:7];
		exp_ctrl.imm = imm_i;
		exp_ctrl.addr_offs = imm_i;
		case (w[6:0])
			rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG: begin
				chk_offs = 1'b0;
				case (f3)
					3'd0: exp_ctrl.aluop = (w[6:0] == rv_isa_pkg::OP_REG && w[30]) ?
						decode_pkg::ALUOP_SUB : decode_pkg::ALUOP_ADD;
					3'd1: exp_ctrl.aluop = decode_pkg::ALUOP_SLL;
					3'd2: exp_ctrl.aluop = decode_pkg::ALUOP_LT;
					3'd3: exp_ctrl.aluop = decode_pkg::ALUOP_LTU;
					3'd4: exp_ctrl.aluop = decode_pkg::ALUOP_XOR;
					3'd5: exp_ctrl.aluop = w[30] ? decode_pkg::ALUOP_SRA : decode_pkg::ALUOP_SRL;
					3'd6: exp_ctrl.aluop = decode_pkg::ALUOP_OR;
					default: exp_ctrl.aluop = decode_pkg::ALUOP_AND;
				endcase
				if (w[6:0] == rv_isa_pkg::OP_IMM) begin
					exp_ctrl.alusrc_b = decode_pkg::SRCB_IMM;
					exp_ctrl.rs2 = '0;
				end
			end
			rv_isa_pkg::OP_LOAD: begin
				exp_ctrl.rs2 = '0;
				exp_ctrl.addr_is_regoffs = 1'b1;
				case (f3)
					3'd0: exp_ctrl.memop = decode_pkg::MEMOP_LB;
					3'd1: exp_ctrl.memop = decode_pkg::MEMOP_LH;
					3'd2: exp_ctrl.memop = decode_pkg::MEMOP_LW;
					3'd4: exp_ctrl.memop = decode_pkg::MEMOP_LBU;
					default: exp_ctrl.memop = decode_pkg::MEMOP_LHU;
				endcase
			end
			rv_isa_pkg::OP_STORE: begin
				exp_ctrl.rd = '0;
				exp_ctrl.addr_offs = imm_s;
				// A store address is rs1 plus the S offset, like a load
				exp_ctrl.addr_is_regoffs = 1'b1;
				case (f3)
					3'd0: exp_ctrl.memop = decode_pkg::MEMOP_SB;
					3'd1: exp_ctrl.memop = decode_pkg::MEMOP_SH;
					default: exp_ctrl.memop = decode_pkg::MEMOP_SW;
				endcase
			end
			rv_isa_pkg::OP_BRANCH: begin
				exp_ctrl.rd = '0;
				exp_ctrl.addr_offs = imm_b;
				exp_ctrl.aluop = !f3[2] ? decode_pkg::ALUOP_SUB :
					(f3[1] ? decode_pkg::ALUOP_LTU : decode_pkg::ALUOP_LT);
				// BNE, BLT and BLTU are taken on a nonzero result
				exp_ctrl.branchcond = (f3[0] ^ f3[2]) ?
					decode_pkg::BCOND_NZERO : decode_pkg::BCOND_ZERO;
			end
			rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
				exp_ctrl.branchcond = decode_pkg::BCOND_ALWAYS;
				exp_ctrl.alusrc_a = decode_pkg::SRCA_PC;
				exp_ctrl.alusrc_b = decode_pkg::SRCB_IMM;
				exp_ctrl.imm = `DEC_PC_STEP;
				exp_ctrl.rs2 = '0;
				if (w[6:0] == rv_isa_pkg::OP_JAL) begin
					exp_ctrl.rs1 = '0;
					exp_ctrl.addr_offs = imm_j;
				end else begin
					exp_ctrl.addr_is_regoffs = 1'b1;
				end
			end
			rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
				chk_offs = 1'b0;
				exp_ctrl.imm = imm_u;
				exp_ctrl.alusrc_b = decode_pkg::SRCB_IMM;
				exp_ctrl.rs1 = '0;
				exp_ctrl.rs2 = '0;
				if (w[6:0] == rv_isa_pkg::OP_AUIPC)
					exp_ctrl.alusrc_a = decode_pkg::SRCA_PC;
			end
			rv_isa_pkg::OP_FENCE: begin
				chk_offs = 1'b0;
				exp_ctrl.rd = '0;
			end
			default: begin
				chk_offs = 1'b0;
				bad = 1'b1;
			end
		endcase
		if (err || bad || !valid) begin
			exp_ctrl.rs1 = '0;
			exp_ctrl.rs2 = '0;
			exp_ctrl.rd = '0;
			exp_ctrl.memop = decode_pkg::MEMOP_NONE;
			exp_ctrl.branchcond = decode_pkg::BCOND_NEVER;
			if (err)
				exp_ctrl.except = decode_pkg::EXCEPT_INSTR_FAULT;
			else if (bad && valid)
				exp_ctrl.except = decode_pkg::EXCEPT_INSTR_ILLEGAL;
		end
		if (m_lock_prev)
			exp_ctrl.branchcond = decode_pkg::BCOND_NEVER;
	endtask

	// Advance the model, set expectations and drive the inputs for one clock cycle
	task automatic cycle(input logic [31:0] w, input logic valid, input logic err,
		input logic stall, input decode_pkg::jump_req_t jmp);
		logic d_stall;
		logic lock_set;
		logic lock_now;
		d_stall = prev_stall || !prev_cir.valid;
		lock_set = prev_jump.now && prev_jump.not_except && d_stall;
		lock_now = (m_lock_prev && d_stall) || lock_set;
		if ((prev_jump.now && !lock_set) || (m_lock_prev && !d_stall))
			m_pc = prev_jump.target;
		else if (!d_stall && !lock_now)
			m_pc = m_pc + `DEC_PC_STEP;
		m_lock_prev = lock_now;
		expect_ctrl(w, valid, err);
		d_stall = stall || !valid;
		lock_set = jmp.now && jmp.not_except && d_stall;
		exp_flags = {valid && !stall, !valid, (m_lock_prev && d_stall) || lock_set};
		exp_pc = m_pc;
		cir_i = {w, valid, err};
		jump_i = jmp;
		x_stall_i = stall;
		prev_cir = cir_i;
		prev_jump = jmp;
		prev_stall = stall;
		@(posedge clk);
		#DRIVE_DLY;
		cycles++;
	endtask

	task automatic rand_cycle(input logic [6:0] opc, input logic [2:0] f3, input logic valid,
		input logic err, input logic stall, input decode_pkg::jump_req_t jmp);
		logic [31:0] w;
		take_bits(25, w);
		w = {w[24:0], opc};
		w[14:12] = f3;
		cycle(w, valid, err, stall, jmp);
	endtask

	task automatic wait_reset_release;
		int n;
		n = 0;
		while (rst_n !== 1'b1) begin
			if (n == 20) begin
				$display("Reset was not released within 20 cycles");
				$display("Test failed");
				$finish;
			end
			@(posedge clk);
			n++;
		end
		#DRIVE_DLY;
	endtask

	// ----------------------------------------
	// Checks run on the falling edge where inputs and outputs have settled
	a_regs: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		{ctrl_o.rs1, ctrl_o.rs2, ctrl_o.rd} == {exp_ctrl.rs1, exp_ctrl.rs2, exp_ctrl.rd})
		else show_fail("rs1_rs2_rd", 32'({exp_ctrl.rs1, exp_ctrl.rs2, exp_ctrl.rd}),
			32'({ctrl_o.rs1, ctrl_o.rs2, ctrl_o.rd}));
	a_imm: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		ctrl_o.imm == exp_ctrl.imm)
		else show_fail("imm", exp_ctrl.imm, ctrl_o.imm);
	a_alu: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		{ctrl_o.alusrc_a, ctrl_o.alusrc_b, ctrl_o.aluop} ==
		{exp_ctrl.alusrc_a, exp_ctrl.alusrc_b, exp_ctrl.aluop})
		else show_fail("src_aluop", 32'({exp_ctrl.alusrc_a, exp_ctrl.alusrc_b, exp_ctrl.aluop}),
			32'({ctrl_o.alusrc_a, ctrl_o.alusrc_b, ctrl_o.aluop}));
	a_memop: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		ctrl_o.memop == exp_ctrl.memop)
		else show_fail("memop", 32'(exp_ctrl.memop), 32'(ctrl_o.memop));
	a_bcond: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		ctrl_o.branchcond == exp_ctrl.branchcond)
		else show_fail("branchcond", 32'(exp_ctrl.branchcond), 32'(ctrl_o.branchcond));
	a_offs: assert property (@(negedge clk) disable iff (!rst_n) chk_on && chk_offs |->
		ctrl_o.addr_offs == exp_ctrl.addr_offs)
		else show_fail("addr_offs", exp_ctrl.addr_offs, ctrl_o.addr_offs);
	a_regoffs: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		ctrl_o.addr_is_regoffs == exp_ctrl.addr_is_regoffs)
		else show_fail("addr_is_regoffs", 32'(exp_ctrl.addr_is_regoffs),
			32'(ctrl_o.addr_is_regoffs));
	a_except: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		ctrl_o.except == exp_ctrl.except)
		else show_fail("except", 32'(exp_ctrl.except), 32'(ctrl_o.except));
	a_pc: assert property (@(negedge clk) disable iff (!rst_n) chk_on |-> pc_o == exp_pc)
		else show_fail("pc", exp_pc, pc_o);
	a_flags: assert property (@(negedge clk) disable iff (!rst_n) chk_on |->
		{cir_use_o, starved_o, cir_lock_o} == exp_flags)
		else show_fail("use_starved_lock", 32'(exp_flags),
			32'({cir_use_o, starved_o, cir_lock_o}));

	initial begin
		#(MAX_CYCLES * 100);
		$display("Timeout after %0d cycles, the run did not reach its end", MAX_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		logic [31:0]           w;
		logic [31:0]           r;
		logic [31:0]           a;
		logic [6:0]            opc;
		logic                  alt_ok;
		decode_pkg::jump_req_t jmp;
		decode_pkg::jump_req_t no_jmp;
		int                    i;
		int                    n;
		lfsr = 32'h7522;
		err_cnt = 0;
		cycles = 0;
		chk_on = 1'b0;
		chk_offs = 1'b0;
		test_name = "reset";
		cir_i = '0;
		jump_i = '0;
		x_stall_i = 1'b0;
		exp_ctrl = '0;
		exp_pc = `DEC_RESET_VECTOR;
		exp_flags = '0;
		m_pc = `DEC_RESET_VECTOR;
		m_lock_prev = 1'b0;
		prev_cir = '0;
		prev_jump = '0;
		prev_stall = 1'b0;
		no_jmp = '0;
		wait_reset_release();
		chk_on = 1'b1;

		repeat (2) cycle(32'h0, 1'b0, 1'b0, 1'b0, no_jmp);

		test_name = "alu_decode";
		repeat (24) begin
			take_bits(1, r);
			opc = r[0] ? rv_isa_pkg::OP_REG : rv_isa_pkg::OP_IMM;
			take_bits(25, w);
			w = {w[24:0], opc};
			take_bits(1, a);
			// Only register ADD and the right shifts have an alternate funct7
			alt_ok = w[14:12] == rv_isa_pkg::F3_SRL ||
				(w[14:12] == rv_isa_pkg::F3_ADD && opc == rv_isa_pkg::OP_REG);
			if (opc == rv_isa_pkg::OP_REG || w[14:12] == rv_isa_pkg::F3_SLL ||
				w[14:12] == rv_isa_pkg::F3_SRL)
				w[31:25] = (alt_ok && a[0]) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
			cycle(w, 1'b1, 1'b0, 1'b0, no_jmp);
		end

		test_name = "mem_and_flow";
		for (i = 0; i < 8; i++) begin
			if (i != 3 && i < 6)
				rand_cycle(rv_isa_pkg::OP_LOAD, 3'(i), 1'b1, 1'b0, 1'b0, no_jmp);
			if (i < 3)
				rand_cycle(rv_isa_pkg::OP_STORE, 3'(i), 1'b1, 1'b0, 1'b0, no_jmp);
			if (i != 2 && i != 3)
				rand_cycle(rv_isa_pkg::OP_BRANCH, 3'(i), 1'b1, 1'b0, 1'b0, no_jmp);
		end
		take_bits(3, r);
		rand_cycle(rv_isa_pkg::OP_JAL, r[2:0], 1'b1, 1'b0, 1'b0, no_jmp);
		rand_cycle(rv_isa_pkg::OP_JALR, 3'd0, 1'b1, 1'b0, 1'b0, no_jmp);
		take_bits(3, r);
		rand_cycle(rv_isa_pkg::OP_LUI, r[2:0], 1'b1, 1'b0, 1'b0, no_jmp);
		take_bits(3, r);
		rand_cycle(rv_isa_pkg::OP_AUIPC, r[2:0], 1'b1, 1'b0, 1'b0, no_jmp);
		rand_cycle(rv_isa_pkg::OP_FENCE, 3'd0, 1'b1, 1'b0, 1'b0, no_jmp);

		test_name = "fetch_fault";
		rand_cycle(rv_isa_pkg::OP_LOAD, 3'd2, 1'b1, 1'b1, 1'b0, no_jmp);
		test_name = "illegal_opcode";
		rand_cycle(7'b1111111, 3'd0, 1'b1, 1'b0, 1'b0, no_jmp);
		test_name = "starved";
		rand_cycle(rv_isa_pkg::OP_STORE, 3'd2, 1'b0, 1'b0, 1'b0, no_jmp);

		test_name = "pc_sequence";
		repeat (3) rand_cycle(rv_isa_pkg::OP_IMM, 3'd0, 1'b1, 1'b0, 1'b0, no_jmp);
		repeat (3) rand_cycle(rv_isa_pkg::OP_IMM, 3'd0, 1'b1, 1'b0, 1'b1, no_jmp);
		take_bits(30, r);
		jmp.now = 1'b1;
		jmp.target = {r[29:0], 2'b00};
		jmp.not_except = 1'b1;
		rand_cycle(rv_isa_pkg::OP_JAL, 3'd0, 1'b1, 1'b0, 1'b0, jmp);
		repeat (2) rand_cycle(rv_isa_pkg::OP_IMM, 3'd0, 1'b1, 1'b0, 1'b0, no_jmp);

		// The jumping JAL stays in the CIR while execute is stalled
		test_name = "cir_lock";
		take_bits(30, r);
		jmp.target = {r[29:0], 2'b00};
		take_bits(25, w);
		w = {w[24:0], rv_isa_pkg::OP_JAL};
		cycle(w, 1'b1, 1'b0, 1'b1, jmp);
		jmp.now = 1'b0;
		repeat (2) cycle(w, 1'b1, 1'b0, 1'b1, jmp);
		cycle(w, 1'b1, 1'b0, 1'b0, jmp);
		n = 0;
		while (cir_lock_o !== 1'b0 && n < 8) begin
			rand_cycle(rv_isa_pkg::OP_IMM, 3'd0, 1'b1, 1'b0, 1'b0, no_jmp);
			n++;
		end
		if (cir_lock_o !== 1'b0) begin
			$display("CIR lock did not release after the execute stall cleared");
			err_cnt++;
		end
		repeat (2) rand_cycle(rv_isa_pkg::OP_IMM, 3'd0, 1'b1, 1'b0, 1'b0, no_jmp);

		$display("Summary: %0d cycles checked, %0d errors", cycles, err_cnt);
		if (err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
